/* hdl/cpuPkg.sv */
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////
  localparam int dataWidth    = 16;  // Data and instruction word
  localparam int regAddrWidth = 4;   // Sixteen registers, r0 reads zero
  localparam int imemDepth    = 256; // Instruction memory words
  localparam int dmemDepth    = 256; // Data memory words

  // Opcodes, top nibble of the word
  localparam logic [3:0] opAdd    = 4'd0;
  localparam logic [3:0] opSub    = 4'd1;
  localparam logic [3:0] opAnd    = 4'd2;
  localparam logic [3:0] opXor    = 4'd3;
  localparam logic [3:0] opAddi   = 4'd4;
  localparam logic [3:0] opLw     = 4'd8;
  localparam logic [3:0] opSw     = 4'd9;
  localparam logic [3:0] opBranch = 4'd12;
  localparam logic [3:0] opHlt    = 4'd15;

  // Branch conditions against Z, N and V
  localparam logic [2:0] condNe     = 3'd0;
  localparam logic [2:0] condEq     = 3'd1;
  localparam logic [2:0] condGt     = 3'd2;
  localparam logic [2:0] condLt     = 3'd3;
  localparam logic [2:0] condGe     = 3'd4;
  localparam logic [2:0] condLe     = 3'd5;
  localparam logic [2:0] condOv     = 3'd6;
  localparam logic [2:0] condAlways = 3'd7;

  // ALU operations, same order as the register-format opcodes
  localparam logic [1:0] aluAdd = 2'd0;
  localparam logic [1:0] aluSub = 2'd1;
  localparam logic [1:0] aluAnd = 2'd2;
  localparam logic [1:0] aluXor = 2'd3;

  // One instruction word, three views
  typedef union packed {
    struct packed {logic [3:0] opcode; logic [3:0] rd; logic [3:0] rs; logic [3:0] rt;} r;
    struct packed {logic [3:0] opcode; logic [3:0] rd; logic [3:0] rs; logic [3:0] imm;} i;
    struct packed {logic [3:0] opcode; logic [2:0] cond; logic [8:0] offset;} b;
  } instrWord;

endpackage

/* hdl/fetch.sv */
`timescale 1ns/10ps

module fetch (
  input  logic        clk,
  input  logic        reset,
  input  logic        pcStall,      // Hold pc
  input  logic        ifIdStall,    // Hold IF/ID
  input  logic        ifIdFlush,    // Zero IF/ID
  input  logic        branchTaken,
  input  logic [15:0] branchTarget,
  input  logic        progWrite,    // Program load strobe, used during reset
  input  logic [7:0]  progAddr,
  input  logic [15:0] progData,
  output logic [15:0] pc,
  output logic [15:0] ifIdInstr,
  output logic [15:0] ifIdPc        // Address of the instruction plus one
);

  logic [cpuPkg::dataWidth-1:0] imem [cpuPkg::imemDepth]; // Word addressed
  logic [15:0] fetchWord; // Word at pc
  logic        halted;    // Set once a HLT sits in decode

  assign fetchWord = imem[pc[7:0]];

  // Program load port
  always_ff @(posedge clk) begin
    if (reset && progWrite) begin
      imem[progAddr] <= progData;
    end
  end

  // Program counter, not-taken prediction
  always_ff @(posedge clk) begin
    if (reset) begin
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      if (pcStall && ifIdFlush) begin
        halted <= 1'b1; // Only HLT holds pc and flushes together
      end
      if (!pcStall && !halted) begin
        pc <= branchTaken ? branchTarget : pc + 16'd1;
      end
    end
  end

  // IF/ID register, a zero word is a bubble
  always_ff @(posedge clk) begin
    if (reset || ifIdFlush || halted) begin
      ifIdInstr <= '0;
      ifIdPc    <= '0;
    end else if (!ifIdStall) begin
      ifIdInstr <= fetchWord;
      ifIdPc    <= pc + 16'd1;
    end
  end

endmodule

/* hdl/decode.sv */
`timescale 1ns/10ps

module decode (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] ifIdInstr,
  input  logic [15:0] ifIdPc,
  input  logic        idExFlush,     // Bubble into ID/EX
  input  logic        wbEnable,
  input  logic [3:0]  wbReg,
  input  logic [15:0] wbData,
  input  logic [2:0]  newFlags,      // {Z, N, V} from execute
  input  logic        flagWrite,
  output logic        branchTaken,
  output logic [15:0] branchTarget,
  output logic        isBranch,
  output logic        isHalt,
  output logic [3:0]  srcA,
  output logic [3:0]  srcB,
  output logic        usesSrcB,
  output logic [15:0] idExOperandA,
  output logic [15:0] idExOperandB,
  output logic [3:0]  idExSrcA,
  output logic [3:0]  idExSrcB,
  output logic [15:0] idExImm,
  output logic        idExUseImm,
  output logic [1:0]  idExAluOp,
  output logic        idExZEn,
  output logic        idExNvEn,
  output logic        idExMemRead,
  output logic        idExMemWrite,
  output logic        idExRegWrite,
  output logic [3:0]  idExDestReg,
  output logic        idExHalt,
  output logic        idExFlagWrite
);

  cpuPkg::instrWord instr;
  logic [15:0] regFile [2**cpuPkg::regAddrWidth]; // Entry 0 is never read
  logic [15:0] readA;
  logic [15:0] readB;
  logic        flagZ;
  logic        flagN;
  logic        flagV;
  logic        condMet;
  logic [15:0] imm;
  logic        useImm;
  logic [1:0]  aluOp;
  logic        zEn;
  logic        nvEn;
  logic        memRead;
  logic        memWrite;
  logic        regWrite;
  logic [3:0]  destReg;

  assign instr = ifIdInstr;

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    srcA     = instr.i.rs;
    srcB     = instr.r.rt;
    usesSrcB = 1'b0;
    imm      = {{12{instr.i.imm[3]}}, instr.i.imm}; // Signed 4-bit immediate
    useImm   = 1'b0;
    aluOp    = cpuPkg::aluAdd;
    zEn      = 1'b0;
    nvEn     = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    destReg  = instr.r.rd;
    isBranch = 1'b0;
    isHalt   = 1'b0;
    case (instr.r.opcode)
      cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opXor: begin
        aluOp    = instr.r.opcode[1:0]; // Opcode low bits are the ALU code
        usesSrcB = 1'b1;
        regWrite = 1'b1;
        zEn      = 1'b1;
        nvEn     = !instr.r.opcode[1];  // ADD and SUB only
      end
      cpuPkg::opAddi: begin
        useImm   = 1'b1;
        regWrite = 1'b1;
        zEn      = 1'b1;
        nvEn     = 1'b1;
      end
      cpuPkg::opLw: begin
        useImm   = 1'b1;
        memRead  = 1'b1;
        regWrite = 1'b1;
      end
      cpuPkg::opSw: begin
        srcB     = instr.i.rd; // Store data register
        usesSrcB = 1'b1;
        useImm   = 1'b1;
        memWrite = 1'b1;
      end
      cpuPkg::opBranch: begin
        srcA     = '0;
        isBranch = 1'b1;
      end
      cpuPkg::opHlt: begin
        srcA   = '0;
        isHalt = 1'b1;
      end
      default: srcA = '0; // Undefined opcodes are no-ops
    endcase
    // A write to r0 is dropped along with its flags, so the zero word is a bubble
    if (destReg == '0) begin
      regWrite = 1'b0;
      zEn      = 1'b0;
      nvEn     = 1'b0;
    end
  end

  // Write-first register file
  assign readA = (srcA == '0) ? '0 : (wbEnable && wbReg == srcA) ? wbData : regFile[srcA];
  assign readB = (srcB == '0) ? '0 : (wbEnable && wbReg == srcB) ? wbData : regFile[srcB];

  always_ff @(posedge clk) begin
    if (wbEnable) begin
      regFile[wbReg] <= wbData;
    end
  end

  // Flag register where N and V follow the instruction now in execute
  always_ff @(posedge clk) begin
    if (reset) begin
      {flagZ, flagN, flagV} <= '0;
    end else if (flagWrite) begin
      flagZ <= newFlags[2];
      if (idExNvEn) begin
        {flagN, flagV} <= newFlags[1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (instr.b.cond)
      cpuPkg::condNe:     condMet = !flagZ;
      cpuPkg::condEq:     condMet = flagZ;
      cpuPkg::condGt:     condMet = !flagZ && !flagN;
      cpuPkg::condLt:     condMet = flagN;
      cpuPkg::condGe:     condMet = flagZ || !flagN;
      cpuPkg::condLe:     condMet = flagN || flagZ;
      cpuPkg::condOv:     condMet = flagV;
      cpuPkg::condAlways: condMet = 1'b1;
      default:            condMet = 1'b0;
    endcase
  end

  assign branchTaken  = isBranch && condMet;
  assign branchTarget = ifIdPc + {{7{instr.b.offset[8]}}, instr.b.offset}; // Word offset

  // ID/EX control with a bubble on flush
  always_ff @(posedge clk) begin
    if (reset || idExFlush) begin
      idExUseImm   <= 1'b0;
      idExAluOp    <= cpuPkg::aluAdd;
      idExZEn      <= 1'b0;
      idExNvEn     <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExRegWrite <= 1'b0;
      idExDestReg  <= '0;
      idExHalt     <= 1'b0;
    end else begin
      idExUseImm   <= useImm;
      idExAluOp    <= aluOp;
      idExZEn      <= zEn;
      idExNvEn     <= nvEn;
      idExMemRead  <= memRead;
      idExMemWrite <= memWrite;
      idExRegWrite <= regWrite;
      idExDestReg  <= destReg;
      idExHalt     <= isHalt;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    idExOperandA <= readA;
    idExOperandB <= readB;
    idExSrcA     <= srcA;
    idExSrcB     <= srcB;
    idExImm      <= imm;
  end

  assign idExFlagWrite = idExZEn || idExNvEn; // Pending flag update

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/10ps

module hazardUnit (
  input  logic [3:0] srcA,          // Decode sources
  input  logic [3:0] srcB,
  input  logic       usesSrcB,
  input  logic       isBranch,
  input  logic       isHalt,
  input  logic       branchTaken,
  input  logic       idExMemRead,   // Load in execute
  input  logic [3:0] idExDestReg,
  input  logic       idExFlagWrite, // Flags not yet written
  output logic       pcStall,
  output logic       ifIdStall,
  output logic       ifIdFlush,
  output logic       idExFlush
);

  logic loadUse;
  logic flagsPending;
  logic hold; // One-cycle stall with a bubble into ID/EX

  assign loadUse = idExMemRead && (idExDestReg != '0) &&
                   ((idExDestReg == srcA) || (usesSrcB && idExDestReg == srcB));
  assign flagsPending = isBranch && idExFlagWrite;
  assign hold         = loadUse || flagsPending;

  assign pcStall   = hold || isHalt;                     // HLT holds pc for good
  assign ifIdStall = hold;
  assign idExFlush = hold;
  assign ifIdFlush = (branchTaken && !hold) || isHalt;   // Stale flags never redirect

endmodule

/* hdl/execute.sv */
`timescale 1ns/10ps

module execute (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] idExOperandA,
  input  logic [15:0] idExOperandB,
  input  logic [3:0]  idExSrcA,
  input  logic [3:0]  idExSrcB,
  input  logic [15:0] idExImm,
  input  logic        idExUseImm,
  input  logic [1:0]  idExAluOp,
  input  logic        idExZEn,
  input  logic        idExNvEn,
  input  logic        idExMemRead,
  input  logic        idExMemWrite,
  input  logic        idExRegWrite,
  input  logic [3:0]  idExDestReg,
  input  logic        idExHalt,
  input  logic        wbEnable,       // MEM/WB forwarding source
  input  logic [3:0]  wbReg,
  input  logic [15:0] wbData,
  output logic [2:0]  newFlags,       // {Z, N, V}
  output logic        flagWrite,
  output logic [15:0] exMemAluResult, // Result or memory address
  output logic [15:0] exMemStoreData,
  output logic        exMemMemRead,
  output logic        exMemMemWrite,
  output logic        exMemRegWrite,
  output logic [3:0]  exMemDestReg,
  output logic        exMemHalt
);

  logic        exHitA;
  logic        exHitB;
  logic [15:0] opA;
  logic [15:0] fwdB;    // Forwarded rt or store data
  logic [15:0] opB;
  logic [15:0] result;
  logic        overflow;

  // Forwarding, EX/MEM first
  assign exHitA = exMemRegWrite && (exMemDestReg != '0) && (exMemDestReg == idExSrcA);
  assign exHitB = exMemRegWrite && (exMemDestReg != '0) && (exMemDestReg == idExSrcB);
  assign opA  = exHitA ? exMemAluResult : (wbEnable && wbReg == idExSrcA) ? wbData : idExOperandA;
  assign fwdB = exHitB ? exMemAluResult : (wbEnable && wbReg == idExSrcB) ? wbData : idExOperandB;
  assign opB  = idExUseImm ? idExImm : fwdB;

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////
  always_comb begin
    overflow = 1'b0;
    case (idExAluOp)
      cpuPkg::aluAdd: begin
        result   = opA + opB;
        overflow = (opA[15] == opB[15]) && (result[15] != opA[15]);
      end
      cpuPkg::aluSub: begin
        result   = opA - opB;
        overflow = (opA[15] != opB[15]) && (result[15] != opA[15]);
      end
      cpuPkg::aluAnd: result = opA & opB;
      cpuPkg::aluXor: result = opA ^ opB;
      default:        result = '0;
    endcase
  end

  assign newFlags  = {result == '0, result[15], overflow};
  assign flagWrite = idExZEn || idExNvEn; // Decode picks N and V by its own enable

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      exMemMemRead  <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemRegWrite <= 1'b0;
      exMemDestReg  <= '0;
      exMemHalt     <= 1'b0;
    end else begin
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemRegWrite <= idExRegWrite;
      exMemDestReg  <= idExDestReg;
      exMemHalt     <= idExHalt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    exMemAluResult <= result;
    exMemStoreData <= fwdB;
  end

endmodule

/* hdl/memStage.sv */
`timescale 1ns/10ps

module memStage (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] exMemAluResult,
  input  logic [15:0] exMemStoreData,
  input  logic        exMemMemRead,
  input  logic        exMemMemWrite,
  input  logic        exMemRegWrite,
  input  logic [3:0]  exMemDestReg,
  input  logic        exMemHalt,
  output logic        wbEnable,    // One pulse per commit
  output logic [3:0]  wbReg,
  output logic [15:0] wbData,
  output logic        hlt          // Sticky until reset
);

  logic [cpuPkg::dataWidth-1:0] dmem [cpuPkg::dmemDepth];
  logic        mwbRegWrite;
  logic        mwbMemToReg;   // Load result selected
  logic [15:0] mwbAluResult;
  logic [15:0] mwbLoadData;

  // Data memory, synchronous write
  always_ff @(posedge clk) begin
    if (exMemMemWrite) begin
      dmem[exMemAluResult[7:0]] <= exMemStoreData;
    end
  end

  // MEM/WB control
  always_ff @(posedge clk) begin
    if (reset) begin
      mwbRegWrite <= 1'b0;
      mwbMemToReg <= 1'b0;
      wbReg       <= '0;
      hlt         <= 1'b0;
    end else begin
      mwbRegWrite <= exMemRegWrite;
      mwbMemToReg <= exMemMemRead;
      wbReg       <= exMemDestReg;
      if (exMemHalt) begin
        hlt <= 1'b1;
      end
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    mwbAluResult <= exMemAluResult;
    mwbLoadData  <= dmem[exMemAluResult[7:0]];
  end

  assign wbEnable = mwbRegWrite && (wbReg != '0);
  assign wbData   = mwbMemToReg ? mwbLoadData : mwbAluResult;

endmodule

/* hdl/cpu.sv */
`timescale 1ns/10ps

module cpu (
  input  logic        clk,
  input  logic        reset,
  input  logic        progWrite,
  input  logic [7:0]  progAddr,
  input  logic [15:0] progData,
  output logic        hlt,
  output logic [15:0] pc,
  output logic        wbEnable,
  output logic [3:0]  wbReg,
  output logic [15:0] wbData
);

  ////////////////////////////////////////////////////////////
  // Stage-to-stage wires
  ////////////////////////////////////////////////////////////
  logic        pcStall;
  logic        ifIdStall;
  logic        ifIdFlush;
  logic        idExFlush;
  logic        branchTaken;
  logic [15:0] branchTarget;
  logic [15:0] ifIdInstr;
  logic [15:0] ifIdPc;
  logic        isBranch;
  logic        isHalt;
  logic [3:0]  srcA;
  logic [3:0]  srcB;
  logic        usesSrcB;
  logic [15:0] idExOperandA;
  logic [15:0] idExOperandB;
  logic [3:0]  idExSrcA;
  logic [3:0]  idExSrcB;
  logic [15:0] idExImm;
  logic        idExUseImm;
  logic [1:0]  idExAluOp;
  logic        idExZEn;
  logic        idExNvEn;
  logic        idExMemRead;
  logic        idExMemWrite;
  logic        idExRegWrite;
  logic [3:0]  idExDestReg;
  logic        idExHalt;
  logic        idExFlagWrite;
  logic [2:0]  newFlags;
  logic        flagWrite;
  logic [15:0] exMemAluResult;
  logic [15:0] exMemStoreData;
  logic        exMemMemRead;
  logic        exMemMemWrite;
  logic        exMemRegWrite;
  logic [3:0]  exMemDestReg;
  logic        exMemHalt;

  fetch i_fetch (
    .clk, .reset, .pcStall, .ifIdStall, .ifIdFlush, .branchTaken, .branchTarget,
    .progWrite, .progAddr, .progData, .pc, .ifIdInstr, .ifIdPc
  );

  decode i_decode (
    .clk, .reset, .ifIdInstr, .ifIdPc, .idExFlush, .wbEnable, .wbReg, .wbData,
    .newFlags, .flagWrite, .branchTaken, .branchTarget, .isBranch, .isHalt,
    .srcA, .srcB, .usesSrcB, .idExOperandA, .idExOperandB, .idExSrcA, .idExSrcB,
    .idExImm, .idExUseImm, .idExAluOp, .idExZEn, .idExNvEn, .idExMemRead,
    .idExMemWrite, .idExRegWrite, .idExDestReg, .idExHalt, .idExFlagWrite
  );

  // Stalls and flushes from decode and execute state
  hazardUnit i_hazardUnit (
    .srcA, .srcB, .usesSrcB, .isBranch, .isHalt, .branchTaken, .idExMemRead,
    .idExDestReg, .idExFlagWrite, .pcStall, .ifIdStall, .ifIdFlush, .idExFlush
  );

  execute i_execute (
    .clk, .reset, .idExOperandA, .idExOperandB, .idExSrcA, .idExSrcB, .idExImm,
    .idExUseImm, .idExAluOp, .idExZEn, .idExNvEn, .idExMemRead, .idExMemWrite,
    .idExRegWrite, .idExDestReg, .idExHalt, .wbEnable, .wbReg, .wbData,
    .newFlags, .flagWrite, .exMemAluResult, .exMemStoreData, .exMemMemRead,
    .exMemMemWrite, .exMemRegWrite, .exMemDestReg, .exMemHalt
  );

  // Write-back feeds decode and forwarding
  memStage i_memStage (
    .clk, .reset, .exMemAluResult, .exMemStoreData, .exMemMemRead, .exMemMemWrite,
    .exMemRegWrite, .exMemDestReg, .exMemHalt, .wbEnable, .wbReg, .wbData, .hlt
  );

endmodule

/* verification/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;

  localparam int clkPeriod      = 20;
  localparam int driveDelay     = 2;   // Inputs change just after the rising edge
  localparam int sampleDelay    = 5;   // Main checks well clear of the edge
  localparam int resetCycles    = 16;
  localparam int quietCycles    = 20;  // Cycles after hlt that must stay silent
  localparam int cyclesPerEntry = 10;  // Watchdog budget per word or commit

  logic        clk;
  logic        reset;
  logic        progWrite;
  logic [7:0]  progAddr;
  logic [15:0] progData;
  logic        hlt;
  logic [15:0] pc;
  logic        wbEnable;
  logic [3:0]  wbReg;
  logic [15:0] wbData;

  logic [7:0]  progAddrQ [$]; // Program image from the data file
  logic [15:0] progWordQ [$];
  logic [3:0]  expRegQ [$];   // Expected commits in program order
  logic [15:0] expDataQ [$];
  logic [15:0] expPc;         // HLT address plus one
  logic        havePc;
  logic        inputLoaded;
  int          commitIdx;     // Next expected commit
  int          watchdogCycles;

  cpu i_cpu (
    .clk, .reset, .progWrite, .progAddr, .progData,
    .hlt, .pc, .wbEnable, .wbReg, .wbData
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////
  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
    if (actual !== expected) begin
      $display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // Data file reader with one record per line and # for comments
  task automatic readInput();
    int          fd;
    int          n;
    int          c;
    logic [7:0]  kind;
    logic [15:0] a;
    logic [15:0] b;
    fd = $fopen("verification/programInput.txt", "r");
    if (fd == 0) begin
      stopWithFailure("Cannot open verification/programInput.txt");
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        n = 0;
        case (kind)
          "#": begin
            c = $fgetc(fd); // Skip to end of line
            while (c != "\n" && c != -1) begin
              c = $fgetc(fd);
            end
            n = 2;
          end
          "P": begin
            n = $fscanf(fd, "%h %h", a, b);
            progAddrQ.push_back(a[7:0]);
            progWordQ.push_back(b);
          end
          "W": begin
            n = $fscanf(fd, "%h %h", a, b);
            expRegQ.push_back(a[3:0]);
            expDataQ.push_back(b);
          end
          "H": begin
            n = $fscanf(fd, "%h", expPc) + 1;
            havePc = 1'b1;
          end
          default: n = 0;
        endcase
        if (n != 2) begin
          stopWithFailure($sformatf("Malformed record of kind '%c' in the data file", kind));
        end
      end
      $fclose(fd);
    end
  endtask

  // Reset held while the program port loads, longer if words remain
  task automatic loadProgram();
    int cycles;
    int i;
    cycles = (progWordQ.size() > resetCycles) ? progWordQ.size() : resetCycles;
    for (i = 0; i < cycles; i++) begin
      @(posedge clk);
      #driveDelay;
      checkValue("pc", pc, 16'h0000);
      checkValue("hlt", {15'd0, hlt}, 16'h0000);
      checkValue("wbEnable", {15'd0, wbEnable}, 16'h0000);
      if (i < progWordQ.size()) begin
        progWrite = 1'b1;
        progAddr  = progAddrQ[i];
        progData  = progWordQ[i];
      end else begin
        progWrite = 1'b0;
      end
    end
    @(posedge clk);
    #driveDelay;
    progWrite = 1'b0;
    reset     = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Commit monitor and watchdog
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (reset === 1'b0 && wbEnable === 1'b1) begin
      if (commitIdx >= expRegQ.size()) begin
        stopWithFailure($sformatf("Unexpected commit to r%0d after the last expected one",
                                  wbReg));
      end else begin
        checkValue("wbReg", {12'd0, wbReg}, {12'd0, expRegQ[commitIdx]});
        checkValue("wbData", wbData, expDataQ[commitIdx]);
        commitIdx++;
      end
    end
  end

  initial begin
    wait (inputLoaded === 1'b1);
    repeat (watchdogCycles) @(posedge clk);
    stopWithFailure($sformatf("Timeout, run not finished after %0d cycles", watchdogCycles));
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    progWrite   = 1'b0;
    progAddr    = '0;
    progData    = '0;
    havePc      = 1'b0;
    inputLoaded = 1'b0;
    commitIdx   = 0;
    readInput();
    watchdogCycles = resetCycles + cyclesPerEntry * (progWordQ.size() + expRegQ.size());
    inputLoaded    = 1'b1;
    loadProgram();
    while (hlt !== 1'b1) begin // Commits are checked by the monitor meanwhile
      @(posedge clk);
      #sampleDelay;
    end
    if (!havePc || commitIdx != expRegQ.size()) begin
      stopWithFailure($sformatf("hlt rose after %0d of %0d expected commits",
                                commitIdx, expRegQ.size()));
    end else begin
      checkValue("pc", pc, expPc);
      repeat (quietCycles) begin
        @(posedge clk);
        #sampleDelay;
        checkValue("hlt", {15'd0, hlt}, 16'h0001); // Sticky until reset
        checkValue("pc", pc, expPc);               // Held for good
      end
      $display("No errors");
      $finish;
    end
  end

endmodule

/* project.f */
hdl/cpuPkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazardUnit.sv
hdl/execute.sv
hdl/memStage.sv
hdl/cpu.sv
verification/cpuTb.sv

/* verification/programInput.txt */
# P addr word = program word, W reg value = expected commit, H pc = pc after HLT
# All numbers hex, text after # is ignored
P 00 4105  # addi r1, r0, 5
P 01 4217  # addi r2, r1, 7      r1 from EX/MEM
P 02 0312  # add  r3, r1, r2     r1 from MEM/WB, r2 from EX/MEM
P 03 1431  # sub  r4, r3, r1
P 04 3543  # xor  r5, r4, r3
P 05 2653  # and  r6, r5, r3
P 06 4708  # addi r7, r0, -8
P 07 0777  # add  r7, r7, r7
P 08 0012  # add  r0, r1, r2     no commit
P 09 9312  # sw   r3, 2(r1)
P 0A 8812  # lw   r8, 2(r1)
P 0B 0988  # add  r9, r8, r8     load-use stall
P 0C 4A9F  # addi r10, r9, -1
P 0D 9A03  # sw   r10, 3(r0)     store data from EX/MEM
P 0E 8B03  # lw   r11, 3(r0)
P 0F 1CBA  # sub  r12, r11, r10  load-use, Z set
P 10 C201  # beq  +1  taken, flags pending
P 11 4D01  # wrong path
P 12 C001  # bne  +1  not taken
P 13 4D03  # addi r13, r0, 3
P 14 C401  # bgt  +1  taken
P 15 4DD1  # wrong path
P 16 1E0D  # sub  r14, r0, r13   N set
P 17 C601  # blt  +1  taken
P 18 4E00  # wrong path
P 19 C801  # bge  +1  not taken
P 1A CA01  # ble  +1  taken
P 1B 4E00  # wrong path
P 1C CC01  # bov  +1  not taken
P 1D 3EEE  # xor  r14, r14, r14  Z set, N kept
P 1E C601  # blt  +1  taken on kept N
P 1F 4D0F  # wrong path
P 20 CE02  # b    +2  always
P 21 4D0F  # wrong path
P 22 4D0F  # never fetched into decode
P 23 411F  # addi r1, r1, -1
P 24 C201  # beq  +1  not taken
P 25 222D  # and  r2, r2, r13
P 26 F000  # hlt
W 1 0005
W 2 000C
W 3 0011
W 4 000C
W 5 001D
W 6 0011
W 7 FFF8
W 7 FFF0
W 8 0011
W 9 0022
W A 0021
W B 0021
W C 0000
W D 0003
W E FFFD
W E 0000
W 1 0004
W 2 0000
H 27
